//--- build.f
+incdir+src
src/axi_wr_pkg.sv
src/ddr_wr_pkg.sv
src/wr_upsize_fifo.sv
src/ddr_wr_ctrl.sv
src/ddr_write_bridge.sv
verification/tb_clkgen.sv
verification/tb_ddr_write_bridge.sv

//--- src/axi_wr_pkg.sv
`default_nettype none

`include "ddr_bridge_macros.svh"

package axi_wr_pkg;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // write address channel
    typedef struct packed {
        logic [3:0]             id;
        logic [`DDR_ADDR_W-1:0] addr;   // word address
        logic [7:0]             len;    // beats minus one
        logic [1:0]             burst;  // incr only, not decoded
    } axi_aw_t;

    // write data channel
    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
        logic                   last;
    } axi_w_t;

    // write response channel
    typedef struct packed {
        logic [3:0] id;
        logic [1:0] resp;
    } axi_b_t;

endpackage

`default_nettype wire

//--- src/ddr_bridge_macros.svh
`ifndef DDR_BRIDGE_MACROS_SVH
`define DDR_BRIDGE_MACROS_SVH

// word address, counted in 32-bit units
`define DDR_ADDR_W        28

// AXI write data side
`define AXI_DATA_W        32
`define AXI_STRB_W        4

// DDR side, one beat holds eight AXI words
`define DDR_DATA_W        256
`define DDR_STRB_W        32
`define DDR_LANES         8

// longest DDR burst, len field is beats minus one
`define DDR_MAX_BEATS     16

// upsizer storage in AXI words, room for two full bursts
`define UPS_DEPTH_WORDS   256

`endif

//--- src/ddr_wr_ctrl.sv
`default_nettype none

`include "ddr_bridge_macros.svh"

module ddr_wr_ctrl (
    input  logic                      clk,
    input  logic                      rstn,

    input  axi_wr_pkg::axi_aw_t       aw,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  axi_wr_pkg::axi_w_t        w,
    input  logic                      w_valid,
    output logic                      w_ready,
    output axi_wr_pkg::axi_b_t        b,
    output logic                      b_valid,
    input  logic                      b_ready,

    output ddr_wr_pkg::ddr_cmd_t      cmd,
    output logic                      cmd_valid,
    input  logic                      cmd_ready,
    input  logic                      wdata_ready,
    input  logic                      wdata_last,

    output logic                      push,
    output logic [`AXI_DATA_W-1:0]    push_word,
    output logic [`AXI_STRB_W-1:0]    push_strb,
    input  logic                      full,
    input  logic                      almost_full
);

    import axi_wr_pkg::*;

    localparam logic [2:0] ST_IDLE   = 3'd0,
                           ST_FILL   = 3'd1,
                           ST_ISSUE  = 3'd2,
                           ST_DATA   = 3'd3,
                           ST_ENDPAD = 3'd4,
                           ST_RESP   = 3'd5;

    logic [2:0]             state;
    logic [2:0]             state_nxt;
    logic [2:0]             start_pad;    // zero words before the first data word
    logic [2:0]             end_pad;      // zero words after the last data word
    logic [`DDR_ADDR_W-1:0] cmd_addr;
    logic [`DDR_ADDR_W-1:0] end_addr;
    logic [5:0]             beats_left;   // up to 33 for an unaligned 256-word burst
    logic [5:0]             cmd_beats;
    logic [3:0]             req_id;
    logic                   last_seen;
    logic                   last_cmd;
    logic                   aw_fire;
    logic                   w_fire;
    logic                   cmd_fire;
    logic                   b_fire;
    logic                   pad_push;

    assign aw_fire  = aw_valid && aw_ready;
    assign w_fire   = w_valid && w_ready;
    assign cmd_fire = cmd_valid && cmd_ready;
    assign b_fire   = b_valid && b_ready;
    assign end_addr = aw.addr + `DDR_ADDR_W'(aw.len);

    assign cmd_beats = (beats_left > 6'(`DDR_MAX_BEATS)) ? 6'(`DDR_MAX_BEATS) : beats_left;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (aw_fire) state_nxt = ST_FILL;
            ST_FILL: begin
                // a full burst goes out first, padding the tail can wait
                if (almost_full) begin
                    state_nxt = ST_ISSUE;
                end else if (last_seen) begin
                    state_nxt = ST_ENDPAD;
                end
            end
            ST_ISSUE:  if (cmd_fire) state_nxt = ST_DATA;
            ST_DATA: begin
                if (wdata_ready && wdata_last) begin
                    state_nxt = last_cmd ? ST_RESP : ST_FILL;
                end
            end
            ST_ENDPAD: if (end_pad == 3'd0) state_nxt = ST_ISSUE;
            ST_RESP:   if (b_fire) state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= ST_IDLE;
            start_pad <= 3'd0;
            end_pad   <= 3'd0;
            last_seen <= 1'b0;
            last_cmd  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (aw_fire) begin
                start_pad <= aw.addr[2:0];
                end_pad   <= 3'd7 - end_addr[2:0];
            end else if (pad_push && !full) begin
                if (state == ST_FILL) begin
                    start_pad <= start_pad - 3'd1;
                end else begin
                    end_pad <= end_pad - 3'd1;
                end
            end
            if (b_fire) begin
                last_seen <= 1'b0;
            end else if (w_fire && w.last) begin
                last_seen <= 1'b1;
            end
            if (cmd_fire) begin
                last_cmd <= (beats_left <= 6'(`DDR_MAX_BEATS));
            end
        end
    end

    // request payload, stepped per issued command
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            cmd_addr   <= {aw.addr[`DDR_ADDR_W-1:3], 3'b000};
            beats_left <= end_addr[8:3] - aw.addr[8:3] + 6'd1;
            req_id     <= aw.id;
        end else if (cmd_fire) begin
            cmd_addr   <= cmd_addr + (`DDR_ADDR_W'(cmd_beats) << 3);
            beats_left <= beats_left - cmd_beats;
        end
    end

    assign pad_push = ((state == ST_FILL) && (start_pad != 3'd0))
                   || ((state == ST_ENDPAD) && (end_pad != 3'd0));

    assign push      = (pad_push && !full) || w_fire;
    assign push_word = pad_push ? '0 : w.data;   // pads carry no data
    assign push_strb = pad_push ? '0 : w.strb;

    assign aw_ready = (state == ST_IDLE);
    assign w_ready  = ((state == ST_FILL) || (state == ST_ISSUE) || (state == ST_DATA))
                   && !full && (start_pad == 3'd0) && !last_seen;

    assign cmd_valid = (state == ST_ISSUE);
    assign cmd.addr  = cmd_addr;
    assign cmd.len   = 4'(cmd_beats - 6'd1);
    assign cmd.id    = req_id;

    assign b_valid = (state == ST_RESP);
    assign b.id    = req_id;   // single outstanding write, id comes straight back
    assign b.resp  = AXI_RESP_OKAY;

    a_cmd_stable: assert property (@(posedge clk) disable iff (!rstn)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else $error("cmd changed while waiting for cmd_ready");

    // master must not present another last before the response
    a_single_last: assert property (@(posedge clk) disable iff (!rstn)
        last_seen |-> !(w_valid && w.last))
        else $error("second w last within one transaction");

endmodule

`default_nettype wire

//--- src/ddr_wr_pkg.sv
`default_nettype none

`include "ddr_bridge_macros.svh"

package ddr_wr_pkg;

    // one write command toward the DDR controller
    typedef struct packed {
        logic [`DDR_ADDR_W-1:0]             addr;  // multiple of 8 words
        logic [$clog2(`DDR_MAX_BEATS)-1:0]  len;   // beats minus one
        logic [3:0]                         id;
    } ddr_cmd_t;

    // Same 256-bit word seen two ways: the DDR port reads it flat,
    // while the upsizer fills it one 32-bit lane at a time.
    typedef union packed {
        logic [`DDR_DATA_W-1:0]                  flat;
        logic [`DDR_LANES-1:0][`AXI_DATA_W-1:0]  lanes;  // lane 0 is the lowest word
    } ddr_beat_u;

endpackage

`default_nettype wire

//--- src/ddr_write_bridge.sv
`default_nettype none

`include "ddr_bridge_macros.svh"

module ddr_write_bridge (
    input  logic                      clk,
    input  logic                      rstn,

    input  axi_wr_pkg::axi_aw_t       aw,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  axi_wr_pkg::axi_w_t        w,
    input  logic                      w_valid,
    output logic                      w_ready,
    output axi_wr_pkg::axi_b_t        b,
    output logic                      b_valid,
    input  logic                      b_ready,

    output ddr_wr_pkg::ddr_cmd_t      cmd,
    output logic                      cmd_valid,
    input  logic                      cmd_ready,
    output ddr_wr_pkg::ddr_beat_u     wdata,
    output logic [`DDR_STRB_W-1:0]    wstrb,
    input  logic                      wdata_ready,
    input  logic                      wdata_last
);

    logic                   push;
    logic [`AXI_DATA_W-1:0] push_word;
    logic [`AXI_STRB_W-1:0] push_strb;
    logic                   full;
    logic                   almost_full;

    ddr_wr_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .b           (b),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .wdata_ready (wdata_ready),
        .wdata_last  (wdata_last),
        .push        (push),
        .push_word   (push_word),
        .push_strb   (push_strb),
        .full        (full),
        .almost_full (almost_full)
    );

    // head beat goes straight to the DDR port, popped by wdata_ready
    wr_upsize_fifo u_fifo (
        .clk         (clk),
        .rstn        (rstn),
        .push        (push),
        .push_word   (push_word),
        .push_strb   (push_strb),
        .wdata_ready (wdata_ready),
        .beat        (wdata),
        .beat_strb   (wstrb),
        .full        (full),
        .almost_full (almost_full),
        .empty       ()
    );

endmodule

`default_nettype wire

//--- src/wr_upsize_fifo.sv
`default_nettype none

`include "ddr_bridge_macros.svh"

module wr_upsize_fifo (
    input  logic                      clk,
    input  logic                      rstn,

    input  logic                      push,
    input  logic [`AXI_DATA_W-1:0]    push_word,
    input  logic [`AXI_STRB_W-1:0]    push_strb,

    input  logic                      wdata_ready,

    output ddr_wr_pkg::ddr_beat_u     beat,
    output logic [`DDR_STRB_W-1:0]    beat_strb,

    output logic                      full,
    output logic                      almost_full,
    output logic                      empty
);

    import ddr_wr_pkg::*;

    localparam int BEATS  = `UPS_DEPTH_WORDS / `DDR_LANES;
    localparam int PTR_W  = $clog2(BEATS);
    localparam int LANE_W = $clog2(`DDR_LANES);

    ddr_beat_u                               mem      [BEATS];
    logic [`DDR_LANES-1:0][`AXI_STRB_W-1:0]  strb_mem [BEATS];

    logic [PTR_W+LANE_W-1:0] wr_ptr;    // word pointer, beat and lane
    logic [PTR_W-1:0]        wr_beat;
    logic [LANE_W-1:0]       wr_lane;
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W:0]          beat_cnt;  // complete beats only
    logic                    beat_done;
    logic                    pop;

    assign wr_beat   = wr_ptr[PTR_W+LANE_W-1:LANE_W];
    assign wr_lane   = wr_ptr[LANE_W-1:0];
    assign beat_done = push && (wr_lane == LANE_W'(`DDR_LANES - 1));  // eighth lane written
    assign pop       = wdata_ready && !empty;

    // lane-wise fill of the wide storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_beat].lanes[wr_lane] <= push_word;
            strb_mem[wr_beat][wr_lane]  <= push_strb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            beat_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({beat_done, pop})
                2'b10:   beat_cnt <= beat_cnt + 1'b1;
                2'b01:   beat_cnt <= beat_cnt - 1'b1;
                default: beat_cnt <= beat_cnt;
            endcase
        end
    end

    // head beat shown until the DDR side takes it
    assign beat      = mem[rd_ptr];
    assign beat_strb = strb_mem[rd_ptr];

    // a partial beat never blocks a slot, so only complete beats count here
    assign full        = (beat_cnt == (PTR_W+1)'(BEATS));
    assign empty       = (beat_cnt == '0);
    assign almost_full = (beat_cnt >= (PTR_W+1)'(`DDR_MAX_BEATS));  // one max burst buffered

    // DDR side must only pull beats that are complete
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn)
        wdata_ready |-> !empty)
        else $error("wdata_ready with no complete beat buffered");

    a_push_not_full: assert property (@(posedge clk) disable iff (!rstn)
        push |-> !full)
        else $error("push into a full upsizer");

endmodule

`default_nettype wire

//--- verification/tb_clkgen.sv
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rstn
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        #2 rstn = 1'b1;  // released just after the third edge
    end

endmodule

`default_nettype wire

//--- verification/tb_ddr_write_bridge.sv
`default_nettype none

`include "ddr_bridge_macros.svh"

module tb_ddr_write_bridge;

    timeunit 1ns;
    timeprecision 100ps;

    import axi_wr_pkg::*;
    import ddr_wr_pkg::*;

    localparam int LIMIT = 2000;  // cycles allowed per wait loop

    logic                   clk;
    logic                   rstn;
    axi_aw_t                aw;
    axi_w_t                 w;
    axi_b_t                 b;
    ddr_cmd_t               cmd;
    ddr_beat_u              wdata;
    logic [`DDR_STRB_W-1:0] wstrb;
    logic                   aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic                   cmd_valid, cmd_ready, wdata_ready, wdata_last;

    int                     errors, checks, timeouts, w_stalls, full_cycles, cmd_hold;
    logic                   stall_en;
    logic [31:0]            lfsr = 32'hf211;
    ddr_cmd_t               exp_cmds[$];
    ddr_beat_u              mem_data[int];  // DDR memory model, keyed by word address
    logic [31:0]            mem_strb[int];

    tb_clkgen u_clkgen (.clk(clk), .rstn(rstn));

    ddr_write_bridge DUT (.*);

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic next_rand_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] word_for(input logic [`DDR_ADDR_W-1:0] wa);
        return {wa[3:0], wa} ^ 32'h5ac3_0f96;
    endfunction

    function automatic axi_aw_t make_req(input logic [3:0] id, input int addr, input int len);
        axi_aw_t r;
        r.id    = id;
        r.addr  = `DDR_ADDR_W'(addr);
        r.len   = 8'(len);
        r.burst = 2'b01;  // incr
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timed out after %0d cycles waiting for %s", LIMIT, what);
        finish_run();
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_cmd(input string name, input ddr_cmd_t exp, input ddr_cmd_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_resp(input string name, input axi_b_t exp, input axi_b_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_beat(input string name, input ddr_beat_u exp, input logic [31:0] exp_s,
                              input ddr_beat_u act, input logic [31:0] act_s);
        checks++;
        if (act.flat !== exp.flat || act_s !== exp_s) begin
            errors++;
            $display("CHECK FAILED %s expected %h strb %h got %h strb %h",
                     name, exp.flat, exp_s, act.flat, act_s);
        end
    endtask

    // lanes inside [addr, addr+len] carry data, the rest are zero padded
    task automatic expected_beat(input axi_aw_t req, input int base,
                                 output ddr_beat_u d, output logic [31:0] s);
        int lane;
        int wa;
        for (lane = 0; lane < `DDR_LANES; lane++) begin
            wa = base + lane;
            if (wa >= int'(req.addr) && wa <= int'(req.addr) + int'(req.len)) begin
                d.lanes[lane]  = word_for(`DDR_ADDR_W'(wa));
                s[lane*4 +: 4] = 4'hf;
            end else begin
                d.lanes[lane]  = '0;
                s[lane*4 +: 4] = 4'h0;
            end
        end
    endtask

    task automatic plan_commands(input axi_aw_t req);
        ddr_cmd_t c;
        int       addr;
        int       left;
        int       n;
        addr = int'(req.addr) & ~7;
        left = (int'(req.addr) + int'(req.len)) / 8 - int'(req.addr) / 8 + 1;
        exp_cmds.delete();
        while (left > 0) begin
            n      = (left > `DDR_MAX_BEATS) ? `DDR_MAX_BEATS : left;
            c.addr = `DDR_ADDR_W'(addr);
            c.len  = 4'(n - 1);
            c.id   = req.id;
            exp_cmds.push_back(c);
            addr   = addr + 8 * n;
            left   = left - n;
        end
    endtask

    task automatic drive_write(input axi_aw_t req);
        int   n;
        int   guard;
        logic done;
        aw       = req;
        aw_valid = 1'b1;
        done     = 1'b0;
        guard    = 0;
        while (!done) begin
            @(negedge clk);
            done = (aw_ready === 1'b1);
            next_cycle();
            guard++;
            if (guard > LIMIT) begin
                report_timeout("aw_ready");
            end
        end
        aw_valid = 1'b0;
        w_stalls = 0;
        n        = 0;
        guard    = 0;
        while (n <= int'(req.len)) begin
            w.data  = word_for(req.addr + `DDR_ADDR_W'(n));
            w.strb  = 4'hf;
            w.last  = (n == int'(req.len));
            w_valid = 1'b1;
            @(negedge clk);
            check_bit("aw_ready", 1'b0, aw_ready);
            done = (w_ready === 1'b1);
            next_cycle();
            if (done) begin
                n++;
            end else begin
                w_stalls++;
            end
            guard++;
            if (guard > LIMIT) begin
                report_timeout("w_ready");
            end
        end
        w_valid = 1'b0;
        w       = '0;
    endtask

    // DDR controller model, takes each command then pulls len+1 beats
    task automatic serve_ddr(input int n_cmds);
        ddr_cmd_t got;
        int       k;
        int       beat;
        int       guard;
        int       hold;
        logic     taken;
        logic     rdy;
        hold = cmd_hold;
        for (k = 0; k < n_cmds; k++) begin
            taken = 1'b0;
            guard = 0;
            while (!taken) begin
                cmd_ready = (hold == 0) && !(stall_en && next_rand_bit());
                @(negedge clk);
                taken = (cmd_valid === 1'b1) && cmd_ready;
                got   = cmd;
                next_cycle();
                if (hold > 0) begin
                    hold--;
                end
                guard++;
                if (guard > LIMIT) begin
                    report_timeout("a DDR command");
                end
            end
            cmd_ready = 1'b0;
            check_cmd("cmd", exp_cmds.pop_front(), got);
            beat  = 0;
            guard = 0;
            while (beat <= int'(got.len)) begin
                rdy         = !(stall_en && next_rand_bit());
                wdata_ready = rdy;
                wdata_last  = rdy && (beat == int'(got.len));
                @(negedge clk);
                if (rdy) begin
                    mem_data[int'(got.addr) + 8 * beat] = wdata;
                    mem_strb[int'(got.addr) + 8 * beat] = wstrb;
                    beat++;
                end
                next_cycle();
                guard++;
                if (guard > LIMIT) begin
                    report_timeout("the DDR data phase");
                end
            end
            wdata_ready = 1'b0;
            wdata_last  = 1'b0;
        end
    endtask

    task automatic check_response(input logic [3:0] id, input int delay);
        axi_b_t exp;
        int     guard;
        int     k;
        exp.id   = id;
        exp.resp = 2'b00;  // OKAY
        guard    = 0;
        @(negedge clk);
        while (b_valid !== 1'b1) begin
            next_cycle();
            @(negedge clk);
            guard++;
            if (guard > LIMIT) begin
                report_timeout("b_valid");
            end
        end
        for (k = 0; k <= delay; k++) begin
            check_resp("b", exp, b);
            check_bit("b_valid", 1'b1, b_valid);
            check_bit("aw_ready", 1'b0, aw_ready);
            next_cycle();
            b_ready = (k == delay);
            @(negedge clk);
        end
        check_bit("b_valid", 1'b1, b_valid);  // handshake on the coming edge
        next_cycle();
        b_ready = 1'b0;
        @(negedge clk);
        check_bit("aw_ready", 1'b1, aw_ready);
        check_bit("b_valid", 1'b0, b_valid);
        check_bit("cmd_valid", 1'b0, cmd_valid);
        next_cycle();
    endtask

    task automatic compare_memory(input axi_aw_t req);
        ddr_beat_u   d;
        logic [31:0] s;
        int          base;
        int          total;
        int          k;
        base  = int'(req.addr) & ~7;
        total = (int'(req.addr) + int'(req.len)) / 8 - int'(req.addr) / 8 + 1;
        check_count("beats written", total, mem_data.num());
        for (k = 0; k < total; k++) begin
            expected_beat(req, base + 8 * k, d, s);
            if (!mem_data.exists(base + 8 * k)) begin
                errors++;
                $display("no DDR beat was written at word address %h", base + 8 * k);
            end else begin
                check_beat("wdata", d, s, mem_data[base + 8 * k], mem_strb[base + 8 * k]);
            end
        end
    endtask

    task automatic run_transfer(input axi_aw_t req, input int hold, input logic stalls,
                                input int b_delay);
        int n_cmds;
        plan_commands(req);
        n_cmds = exp_cmds.size();
        mem_data.delete();
        mem_strb.delete();
        cmd_hold    = hold;
        stall_en    = stalls;
        full_cycles = 0;
        fork
            drive_write(req);
            serve_ddr(n_cmds);
        join
        // start padding and a full upsizer are what hold off W
        check_count("w_ready low cycles", int'(req.addr[2:0]) + full_cycles, w_stalls);
        check_response(req.id, b_delay);
        compare_memory(req);
    endtask

    task automatic test_reset_state();
        int guard;
        @(posedge clk);
        @(negedge clk);
        guard = 0;
        while (rstn !== 1'b1) begin
            check_bit("cmd_valid", 1'b0, cmd_valid);
            check_bit("w_ready", 1'b0, w_ready);
            check_bit("b_valid", 1'b0, b_valid);
            @(negedge clk);
            guard++;
            if (guard > LIMIT) begin
                report_timeout("reset release");
            end
        end
        check_bit("cmd_valid", 1'b0, cmd_valid);  // first cycle out of reset
        check_bit("w_ready", 1'b0, w_ready);
        check_bit("b_valid", 1'b0, b_valid);
        check_bit("aw_ready", 1'b1, aw_ready);
        next_cycle();
    endtask

    task automatic test_long_burst();
        run_transfer(make_req(4'h3, 'h400, 255), 300, 1'b0, 1);  // command held, FIFO fills
        run_transfer(make_req(4'h5, 'h403, 255), 300, 1'b0, 2);  // 33 beats, fills before last
        if (full_cycles == 0) begin
            errors++;
            $display("upsizer FIFO never held off a pending W word while the command was held");
        end
    endtask

    // w_ready must drop whenever the upsizer is full
    always @(negedge clk) begin
        if (DUT.u_fifo.full === 1'b1) begin
            if (w_valid === 1'b1) begin
                full_cycles++;
            end
            check_bit("w_ready", 1'b0, w_ready);
        end
    end

    initial begin
        aw          = '0;
        aw_valid    = 1'b0;
        w           = '0;
        w_valid     = 1'b0;
        b_ready     = 1'b0;
        cmd_ready   = 1'b0;
        wdata_ready = 1'b0;
        wdata_last  = 1'b0;
        stall_en    = 1'b0;
        cmd_hold    = 0;
        full_cycles = 0;
        test_reset_state();
        run_transfer(make_req(4'h1, 'h100, 7), 0, 1'b0, 0);    // aligned, one beat
        run_transfer(make_req(4'h2, 'h203, 6), 0, 1'b0, 3);    // padded at both ends
        test_long_burst();
        run_transfer(make_req(4'h4, 'h800, 159), 0, 1'b1, 5);  // 20 beats, DDR stalls
        finish_run();
    end

endmodule

`default_nettype wire
